/* Bender.yml */
package:
  name: retire_rename_map

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/renamePkg.sv
      - common/retirePkg.sv
      - archMap/archMapRam.sv
      - archMap/archMapTable.sv
      - verilog/specMapTable.sv
      - verilog/retireRenameTop.sv
  - target: simulation
    include_dirs:
      - common
      - sim
    files:
      - sim/retireRenameTb.sv

/* archMap/archMapRam.sv */
// Architectural map storage
// Four asynchronous reads, four clocked writes, identity map on reset

`timescale 1ns/1ps

`include "renameMap_cfg.svh"

module archMapRam (
  input  logic               clk,
  input  logic               reset,
  input  renamePkg::logIdx_t  rdAddr0_i,
  input  renamePkg::logIdx_t  rdAddr1_i,
  input  renamePkg::logIdx_t  rdAddr2_i,
  input  renamePkg::logIdx_t  rdAddr3_i,
  input  logic               we0_i,
  input  logic               we1_i,
  input  logic               we2_i,
  input  logic               we3_i,
  input  renamePkg::logIdx_t  wrAddr0_i,
  input  renamePkg::logIdx_t  wrAddr1_i,
  input  renamePkg::logIdx_t  wrAddr2_i,
  input  renamePkg::logIdx_t  wrAddr3_i,
  input  renamePkg::physTag_t wrData0_i,
  input  renamePkg::physTag_t wrData1_i,
  input  renamePkg::physTag_t wrData2_i,
  input  renamePkg::physTag_t wrData3_i,
  output renamePkg::physTag_t rdData0_o,
  output renamePkg::physTag_t rdData1_o,
  output renamePkg::physTag_t rdData2_o,
  output renamePkg::physTag_t rdData3_o
);

  import renamePkg::*;

  // One physical tag per logical register
  physTag_t mapArray [`NUM_LOG_REGS];

  // Reads see the contents before this edge's writes
  assign rdData0_o = mapArray[rdAddr0_i];
  assign rdData1_o = mapArray[rdAddr1_i];
  assign rdData2_o = mapArray[rdAddr2_i];
  assign rdData3_o = mapArray[rdAddr3_i];

  // ##############################
  // Write ports
  // ##############################

  // Later assignments win, so port 3 has the highest priority
  always_ff @(posedge clk) begin
    if (reset) begin
      // Register i starts out mapped to tag i
      for (int i = 0; i < `NUM_LOG_REGS; i++) begin
        mapArray[i] <= physTag_t'(i);
      end
    end else begin
      if (we0_i) mapArray[wrAddr0_i] <= wrData0_i;
      if (we1_i) mapArray[wrAddr1_i] <= wrData1_i;
      if (we2_i) mapArray[wrAddr2_i] <= wrData2_i;
      if (we3_i) mapArray[wrAddr3_i] <= wrData3_i;
    end
  end

endmodule

/* archMap/archMapTable.sv */
// Architectural map table
// Retires up to four mappings per cycle, picks the register each slot frees,
// and walks the table four entries per cycle on recovery

`timescale 1ns/1ps

`include "renameMap_cfg.svh"

module archMapTable (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 commitValid0_i,
  input  logic                 commitValid1_i,
  input  logic                 commitValid2_i,
  input  logic                 commitValid3_i,
  input  renamePkg::mapPacket_t commitPacket0_i,
  input  renamePkg::mapPacket_t commitPacket1_i,
  input  renamePkg::mapPacket_t commitPacket2_i,
  input  renamePkg::mapPacket_t commitPacket3_i,
  input  logic                 recoverStart_i,
  output logic                 releaseValid0_o,
  output logic                 releaseValid1_o,
  output logic                 releaseValid2_o,
  output logic                 releaseValid3_o,
  output renamePkg::physTag_t   releaseTag0_o,
  output renamePkg::physTag_t   releaseTag1_o,
  output renamePkg::physTag_t   releaseTag2_o,
  output renamePkg::physTag_t   releaseTag3_o,
  output logic                 recoverValid_o,
  output renamePkg::mapPacket_t recoverPacket0_o,
  output renamePkg::mapPacket_t recoverPacket1_o,
  output renamePkg::mapPacket_t recoverPacket2_o,
  output renamePkg::mapPacket_t recoverPacket3_o,
  output logic                 recoverBusy_o
);

  import renamePkg::*;
  import retirePkg::*;

  walkState_t walkState;
  walkCount_t walkCount;
  logic       commitOpen;

  // Slot fields, slot 0 is the oldest
  logIdx_t    dest0, dest1, dest2, dest3;
  physTag_t   tag0, tag1, tag2, tag3;
  logic       superseded0, superseded1, superseded2;

  logIdx_t    rdAddr0, rdAddr1, rdAddr2, rdAddr3;
  physTag_t   rdData0, rdData1, rdData2, rdData3;

  // ##############################
  // Commit decode
  // ##############################

  assign dest0 = commitPacket0_i[`PHYS_TAG_BITS +: `LOG_IDX_BITS];
  assign dest1 = commitPacket1_i[`PHYS_TAG_BITS +: `LOG_IDX_BITS];
  assign dest2 = commitPacket2_i[`PHYS_TAG_BITS +: `LOG_IDX_BITS];
  assign dest3 = commitPacket3_i[`PHYS_TAG_BITS +: `LOG_IDX_BITS];
  assign tag0  = commitPacket0_i[`PHYS_TAG_BITS-1:0];
  assign tag1  = commitPacket1_i[`PHYS_TAG_BITS-1:0];
  assign tag2  = commitPacket2_i[`PHYS_TAG_BITS-1:0];
  assign tag3  = commitPacket3_i[`PHYS_TAG_BITS-1:0];

  // Only a valid younger slot can supersede an older one
  assign superseded0 = ((dest0 == dest1) && commitValid1_i) ||
                       ((dest0 == dest2) && commitValid2_i) ||
                       ((dest0 == dest3) && commitValid3_i);
  assign superseded1 = ((dest1 == dest2) && commitValid2_i) ||
                       ((dest1 == dest3) && commitValid3_i);
  assign superseded2 = (dest2 == dest3) && commitValid3_i;

  // Commits arriving mid-walk are dropped
  assign commitOpen = (walkState == walkIdle);

  // ##############################
  // Map storage
  // ##############################

  // Slot destinations when idle, current group while walking
  assign rdAddr0 = commitOpen ? dest0 : {walkCount, 2'd0};
  assign rdAddr1 = commitOpen ? dest1 : {walkCount, 2'd1};
  assign rdAddr2 = commitOpen ? dest2 : {walkCount, 2'd2};
  assign rdAddr3 = commitOpen ? dest3 : {walkCount, 2'd3};

  archMapRam mapRam (
    .clk       (clk),
    .reset     (reset),
    .rdAddr0_i (rdAddr0),
    .rdAddr1_i (rdAddr1),
    .rdAddr2_i (rdAddr2),
    .rdAddr3_i (rdAddr3),
    .we0_i     (commitOpen && commitValid0_i && !superseded0),
    .we1_i     (commitOpen && commitValid1_i && !superseded1),
    .we2_i     (commitOpen && commitValid2_i && !superseded2),
    .we3_i     (commitOpen && commitValid3_i),
    .wrAddr0_i (dest0),
    .wrAddr1_i (dest1),
    .wrAddr2_i (dest2),
    .wrAddr3_i (dest3),
    .wrData0_i (tag0),
    .wrData1_i (tag1),
    .wrData2_i (tag2),
    .wrData3_i (tag3),
    .rdData0_o (rdData0),
    .rdData1_o (rdData1),
    .rdData2_o (rdData2),
    .rdData3_o (rdData3)
  );

  // Release select
  // A superseded slot frees its own new tag, others free the old mapping
  assign releaseValid0_o = commitOpen && commitValid0_i;
  assign releaseValid1_o = commitOpen && commitValid1_i;
  assign releaseValid2_o = commitOpen && commitValid2_i;
  assign releaseValid3_o = commitOpen && commitValid3_i;
  assign releaseTag0_o   = superseded0 ? tag0 : rdData0;
  assign releaseTag1_o   = superseded1 ? tag1 : rdData1;
  assign releaseTag2_o   = superseded2 ? tag2 : rdData2;
  assign releaseTag3_o   = rdData3;  // youngest slot is never superseded

  // ##############################
  // Recovery walk
  // ##############################

  assign recoverBusy_o    = (walkState == walkActive);
  assign recoverValid_o   = (walkState == walkActive);
  assign recoverPacket0_o = {rdAddr0, rdData0};
  assign recoverPacket1_o = {rdAddr1, rdData1};
  assign recoverPacket2_o = {rdAddr2, rdData2};
  assign recoverPacket3_o = {rdAddr3, rdData3};

  // One group per cycle, back to idle after the last group
  always_ff @(posedge clk) begin
    if (reset) begin
      walkState <= walkIdle;
      walkCount <= '0;
    end else begin
      case (walkState)
        walkIdle: begin
          walkCount <= '0;
          if (recoverStart_i) walkState <= walkActive;
        end
        walkActive: begin
          walkCount <= walkCount_t'(walkCount + 1'b1);
          if (walkCount == walkCount_t'(`WALK_GROUPS - 1)) walkState <= walkIdle;
        end
        default: walkState <= walkIdle;
      endcase
    end
  end

endmodule

/* build.f */
+incdir+common
+incdir+sim
common/renamePkg.sv
common/retirePkg.sv
archMap/archMapRam.sv
archMap/archMapTable.sv
verilog/specMapTable.sv
verilog/retireRenameTop.sv
sim/retireRenameTb.sv

/* common/renameMap_cfg.svh */
// Rename map sizing
// Logical and physical register file sizes for the retirement-side renamer

`ifndef RENAME_MAP_CFG_SVH
`define RENAME_MAP_CFG_SVH

// ##############################
// Logical register file
// ##############################

// Architectural registers visible to software
`define NUM_LOG_REGS 32
`define LOG_IDX_BITS $clog2(`NUM_LOG_REGS)

// ##############################
// Physical register file
// ##############################

`define NUM_PHYS_REGS 64
`define PHYS_TAG_BITS $clog2(`NUM_PHYS_REGS)

// Recovery walk moves four map entries per cycle
`define WALK_GROUPS (`NUM_LOG_REGS / 4)

`endif

/* common/renamePkg.sv */
// Rename types
// Register identifiers and the map packet shared by commit and recovery

package renamePkg;

  `include "renameMap_cfg.svh"

  // Logical destination index
  typedef logic [`LOG_IDX_BITS-1:0] logIdx_t;

  // Physical register tag
  typedef logic [`PHYS_TAG_BITS-1:0] physTag_t;

  // Map packet for commit and recovery
  // Logical index in the upper bits, physical tag below
  typedef logic [`LOG_IDX_BITS+`PHYS_TAG_BITS-1:0] mapPacket_t;

endpackage

/* common/retirePkg.sv */
// Retirement types
// Recovery walk state and walk group counter

package retirePkg;

  `include "renameMap_cfg.svh"

  // Walk sequencer states
  typedef enum logic {
    walkIdle,
    walkActive
  } walkState_t;

  // One count per group of four map entries
  typedef logic [$clog2(`WALK_GROUPS)-1:0] walkCount_t;

endpackage

/* sim/retireModel.svh */
// Retirement renamer reference model
// Architectural and speculative map copies plus the release rule for a commit window

`ifndef RETIRE_MODEL_SVH
`define RETIRE_MODEL_SVH

// Model copies of both map tables
physTag_t archModel [`NUM_LOG_REGS];
physTag_t specModel [`NUM_LOG_REGS];

// Releases expected for the current window
logic     [3:0] expRelValid;
physTag_t [3:0] expRelTag;

// Both tables start out as the identity map
function automatic void resetModel();
  for (int i = 0; i < `NUM_LOG_REGS; i++) begin
    archModel[i] = physTag_t'(i);
    specModel[i] = physTag_t'(i);
  end
endfunction

// Predict the releases of one window, then retire it into the architectural copy
function automatic void commitModel(input logic [3:0] valid, input logIdx_t [3:0] dest,
                                    input physTag_t [3:0] tag);
  logic [3:0] writes;
  for (int s = 0; s < 4; s++) begin
    writes[s] = valid[s];
    // A valid younger slot with the same destination takes over the write
    for (int y = s + 1; y < 4; y++) begin
      if (valid[y] && (dest[y] == dest[s])) begin
        writes[s] = 1'b0;
      end
    end
    expRelValid[s] = valid[s];
    expRelTag[s]   = (valid[s] && !writes[s]) ? tag[s] : archModel[dest[s]];
  end
  for (int s = 0; s < 4; s++) begin
    if (writes[s]) begin
      archModel[dest[s]] = tag[s];
    end
  end
endfunction

// Speculative rename write
function automatic void renameModel(input logIdx_t dest, input physTag_t tag);
  specModel[dest] = tag;
endfunction

// Recovery copies the whole architectural map
function automatic void recoverModel();
  for (int i = 0; i < `NUM_LOG_REGS; i++) begin
    specModel[i] = archModel[i];
  end
endfunction

`endif

/* sim/retireRenameTb.sv */
// Retirement renamer testbench
// Seeded random commits, rename writes and a recovery walk checked against a model

`timescale 1ns/1ps

`include "renameMap_cfg.svh"

module retireRenameTb;

  import renamePkg::*;

  logic       clk;
  logic       reset;
  logic       commitValid0_i, commitValid1_i, commitValid2_i, commitValid3_i;
  mapPacket_t commitPacket0_i, commitPacket1_i, commitPacket2_i, commitPacket3_i;
  logic       recoverStart_i;
  logic       releaseValid0_o, releaseValid1_o, releaseValid2_o, releaseValid3_o;
  physTag_t   releaseTag0_o, releaseTag1_o, releaseTag2_o, releaseTag3_o;
  logic       recoverBusy_o;
  logic       renameWe_i;
  logIdx_t    renameDest_i;
  physTag_t   renameTag_i;
  logIdx_t    lookupDest_i;
  physTag_t   lookupTag_o;

  // Release outputs gathered per slot
  logic     [3:0] relValid;
  physTag_t [3:0] relTag;

  int checkCount;
  int errorCount;
  int testsRun;
  int testsFailed;
  int testErrStart;
  bit timedOut;

  `include "retireModel.svh"

  assign relValid = {releaseValid3_o, releaseValid2_o, releaseValid1_o, releaseValid0_o};
  assign relTag   = {releaseTag3_o, releaseTag2_o, releaseTag1_o, releaseTag0_o};

  retireRenameTop dut (
    .clk             (clk),
    .reset           (reset),
    .commitValid0_i  (commitValid0_i),
    .commitValid1_i  (commitValid1_i),
    .commitValid2_i  (commitValid2_i),
    .commitValid3_i  (commitValid3_i),
    .commitPacket0_i (commitPacket0_i),
    .commitPacket1_i (commitPacket1_i),
    .commitPacket2_i (commitPacket2_i),
    .commitPacket3_i (commitPacket3_i),
    .recoverStart_i  (recoverStart_i),
    .releaseValid0_o (releaseValid0_o),
    .releaseValid1_o (releaseValid1_o),
    .releaseValid2_o (releaseValid2_o),
    .releaseValid3_o (releaseValid3_o),
    .releaseTag0_o   (releaseTag0_o),
    .releaseTag1_o   (releaseTag1_o),
    .releaseTag2_o   (releaseTag2_o),
    .releaseTag3_o   (releaseTag3_o),
    .recoverBusy_o   (recoverBusy_o),
    .renameWe_i      (renameWe_i),
    .renameDest_i    (renameDest_i),
    .renameTag_i     (renameTag_i),
    .lookupDest_i    (lookupDest_i),
    .lookupTag_o     (lookupTag_o)
  );

  // 8 ns clock
  initial clk = 1'b0;
  always #4 clk = ~clk;

  // ##############################
  // Helpers
  // ##############################

  // Drive point sits 1 ns after the rising edge
  task automatic nextCycle();
    @(posedge clk);
    #1;
  endtask

  task automatic compareValue(input logic [31:0] actual, input logic [31:0] expected,
                              input string what);
    checkCount++;
    if (actual !== expected) begin
      errorCount++;
      $display("FAILED at %0t: %s, got %0d, expected %0d", $time, what, actual, expected);
    end
  endtask

  function automatic logIdx_t randomDest();
    return logIdx_t'($urandom_range(`NUM_LOG_REGS - 1, 0));
  endfunction

  function automatic physTag_t randomTag();
    return physTag_t'($urandom_range(`NUM_PHYS_REGS - 1, 0));
  endfunction

  task automatic driveWindow(input logic [3:0] valid, input logIdx_t [3:0] dest,
                             input physTag_t [3:0] tag);
    commitValid0_i  = valid[0];
    commitValid1_i  = valid[1];
    commitValid2_i  = valid[2];
    commitValid3_i  = valid[3];
    commitPacket0_i = {dest[0], tag[0]};
    commitPacket1_i = {dest[1], tag[1]};
    commitPacket2_i = {dest[2], tag[2]};
    commitPacket3_i = {dest[3], tag[3]};
  endtask

  task automatic clearInputs();
    driveWindow(4'b0000, '0, '0);
    recoverStart_i = 1'b0;
    renameWe_i     = 1'b0;
    renameDest_i   = '0;
    renameTag_i    = '0;
    lookupDest_i   = '0;
  endtask

  // One commit window with its releases sampled 2 ns after the drive point
  task automatic runWindow(input logic [3:0] valid, input logIdx_t [3:0] dest,
                           input physTag_t [3:0] tag);
    nextCycle();
    driveWindow(valid, dest, tag);
    commitModel(valid, dest, tag);
    #2;
    for (int s = 0; s < 4; s++) begin
      compareValue(relValid[s], expRelValid[s], $sformatf("slot %0d release valid", s));
      if (expRelValid[s]) begin
        compareValue(relTag[s], expRelTag[s], $sformatf("slot %0d release tag", s));
      end
    end
  endtask

  task automatic reportTest(input string name);
    int newErrors;
    newErrors = errorCount - testErrStart;
    testsRun++;
    if (newErrors != 0) begin
      testsFailed++;
    end
    $display("Test %0d %s: %0d mismatches", testsRun, name, newErrors);
    testErrStart = errorCount;
  endtask

  // ##############################
  // Tests
  // ##############################

  // Identity map after reset and the first release of each register
  task automatic checkResetState();
    logic     [3:0] valid;
    logIdx_t  [3:0] dest;
    physTag_t [3:0] tag;
    int             slot;
    compareValue(recoverBusy_o, 0, "busy after reset");
    compareValue(relValid, 0, "release valid after reset");
    for (int i = 0; i < `NUM_LOG_REGS; i++) begin
      nextCycle();
      lookupDest_i = logIdx_t'(i);
      #2;
      compareValue(lookupTag_o, i, $sformatf("reset lookup of r%0d", i));
    end
    // One commit to a distinct register in each group of four
    for (int i = 0; i < `NUM_LOG_REGS / 4; i++) begin
      slot       = $urandom_range(3, 0);
      valid      = '0;
      dest       = '0;
      tag        = '0;
      valid[slot] = 1'b1;
      dest[slot] = logIdx_t'(i * 4 + $urandom_range(3, 0));
      tag[slot]  = randomTag();
      runWindow(valid, dest, tag);
      compareValue(relTag[slot], dest[slot], "first commit release");
    end
  endtask

  task automatic singleCommits();
    logic     [3:0] valid;
    logIdx_t  [3:0] dest;
    physTag_t [3:0] tag;
    int             slot;
    for (int n = 0; n < 40; n++) begin
      slot        = $urandom_range(3, 0);
      valid       = '0;
      valid[slot] = 1'b1;
      for (int s = 0; s < 4; s++) begin
        dest[s] = randomDest();
        tag[s]  = randomTag();
      end
      runWindow(valid, dest, tag);
    end
  endtask

  // Full windows with a forced repeated destination
  task automatic duplicateWindows();
    logic     [3:0] valid;
    logIdx_t  [3:0] dest;
    physTag_t [3:0] tag;
    int             first;
    int             second;
    int             youngest;
    logIdx_t        dupDest;
    physTag_t       keptTag;
    for (int n = 0; n < 30; n++) begin
      for (int s = 0; s < 4; s++) begin
        dest[s] = randomDest();
        tag[s]  = randomTag();
      end
      first        = $urandom_range(2, 0);
      second       = $urandom_range(3, first + 1);
      dest[second] = dest[first];
      dupDest      = dest[first];
      youngest     = first;
      for (int s = 0; s < 4; s++) begin
        if (dest[s] == dupDest) begin
          youngest = s;
        end
      end
      keptTag = tag[youngest];
      runWindow(4'b1111, dest, tag);
      // Follow-up commit shows which slot wrote the table
      valid   = 4'b0001;
      dest    = '0;
      dest[0] = dupDest;
      tag     = '0;
      tag[0]  = randomTag();
      runWindow(valid, dest, tag);
      compareValue(relTag[0], keptTag, "youngest duplicate wrote the table");
    end
  endtask

  task automatic invalidSlots();
    logic     [3:0] valid;
    logIdx_t  [3:0] dest;
    physTag_t [3:0] tag;
    logIdx_t        d;
    physTag_t       oldMap;
    d      = randomDest();
    oldMap = archModel[d];
    dest   = {logIdx_t'(d + 1), d, d, d};
    tag    = {randomTag(), randomTag(), randomTag(), randomTag()};
    // Invalid slots 1 and 2 share slot 0's destination
    runWindow(4'b1001, dest, tag);
    compareValue(relTag[0], oldMap, "slot 0 not superseded by invalid slots");
    compareValue(relValid[1], 0, "invalid slot 1 release");
    compareValue(relValid[2], 0, "invalid slot 2 release");
    // Narrow destination range makes collisions common
    for (int n = 0; n < 30; n++) begin
      valid = 4'($urandom_range(15, 0));
      for (int s = 0; s < 4; s++) begin
        dest[s] = logIdx_t'($urandom_range(3, 0));
        tag[s]  = randomTag();
      end
      runWindow(valid, dest, tag);
    end
  endtask

  // Old mapping stays on the lookup port until the write edge
  task automatic renameWrites();
    logIdx_t  dest;
    physTag_t tag;
    for (int n = 0; n < 40; n++) begin
      dest = randomDest();
      tag  = randomTag();
      nextCycle();
      driveWindow(4'b0000, '0, '0);
      renameWe_i   = 1'b1;
      renameDest_i = dest;
      renameTag_i  = tag;
      lookupDest_i = dest;
      #2;
      compareValue(lookupTag_o, specModel[dest], "lookup before rename write edge");
      renameModel(dest, tag);
      nextCycle();
      renameWe_i = 1'b0;
      #2;
      compareValue(lookupTag_o, tag, "rename write visible next cycle");
    end
  endtask

  task automatic recoveryWalk();
    int busyCycles;
    nextCycle();
    driveWindow(4'b0000, '0, '0);
    recoverStart_i = 1'b1;
    nextCycle();
    recoverStart_i = 1'b0;
    #2;
    busyCycles = 0;
    while ((recoverBusy_o === 1'b1) && (busyCycles < 20)) begin
      busyCycles++;
      nextCycle();
      #2;
    end
    if (recoverBusy_o === 1'b1) begin
      timedOut = 1'b1;
      $display("Recovery walk timed out, recoverBusy_o still high after 20 cycles");
    end else begin
      compareValue(busyCycles, `WALK_GROUPS, "recovery busy cycles");
      recoverModel();
      // Earlier rename writes must be gone
      for (int i = 0; i < `NUM_LOG_REGS; i++) begin
        nextCycle();
        lookupDest_i = logIdx_t'(i);
        #2;
        compareValue(lookupTag_o, specModel[i], $sformatf("recovered lookup of r%0d", i));
      end
    end
  endtask

  task automatic finishRun();
    $display("Summary: %0d tests, %0d failed, %0d checks, %0d mismatches",
             testsRun, testsFailed, checkCount, errorCount);
    if ((errorCount == 0) && !timedOut) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  endtask

  // ##############################
  // Main sequence
  // ##############################

  initial begin
    void'($urandom(32'he560));
    checkCount   = 0;
    errorCount   = 0;
    testsRun     = 0;
    testsFailed  = 0;
    testErrStart = 0;
    timedOut     = 1'b0;
    reset        = 1'b1;
    clearInputs();
    resetModel();
    repeat (5) @(posedge clk);
    #1;
    reset = 1'b0;
    #2;
    checkResetState();
    reportTest("reset identity and first release");
    singleCommits();
    reportTest("single slot commits");
    duplicateWindows();
    reportTest("duplicate destinations");
    invalidSlots();
    reportTest("invalid slots");
    renameWrites();
    reportTest("rename writes");
    recoveryWalk();
    reportTest("recovery walk");
    finishRun();
  end

endmodule

/* verilog/retireRenameTop.sv */
// Retirement renamer top
// Joins the architectural map table to the speculative map table

`timescale 1ns/1ps

module retireRenameTop (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 commitValid0_i,
  input  logic                 commitValid1_i,
  input  logic                 commitValid2_i,
  input  logic                 commitValid3_i,
  input  renamePkg::mapPacket_t commitPacket0_i,
  input  renamePkg::mapPacket_t commitPacket1_i,
  input  renamePkg::mapPacket_t commitPacket2_i,
  input  renamePkg::mapPacket_t commitPacket3_i,
  input  logic                 recoverStart_i,
  output logic                 releaseValid0_o,
  output logic                 releaseValid1_o,
  output logic                 releaseValid2_o,
  output logic                 releaseValid3_o,
  output renamePkg::physTag_t   releaseTag0_o,
  output renamePkg::physTag_t   releaseTag1_o,
  output renamePkg::physTag_t   releaseTag2_o,
  output renamePkg::physTag_t   releaseTag3_o,
  output logic                 recoverBusy_o,
  input  logic                 renameWe_i,
  input  renamePkg::logIdx_t    renameDest_i,
  input  renamePkg::physTag_t   renameTag_i,
  input  renamePkg::logIdx_t    lookupDest_i,
  output renamePkg::physTag_t   lookupTag_o
);

  import renamePkg::*;

  // Recovery path from the architectural to the speculative table
  logic       recoverValid;
  mapPacket_t recoverPacket0, recoverPacket1, recoverPacket2, recoverPacket3;

  archMapTable archTable (
    .clk              (clk),
    .reset            (reset),
    .commitValid0_i   (commitValid0_i),
    .commitValid1_i   (commitValid1_i),
    .commitValid2_i   (commitValid2_i),
    .commitValid3_i   (commitValid3_i),
    .commitPacket0_i  (commitPacket0_i),
    .commitPacket1_i  (commitPacket1_i),
    .commitPacket2_i  (commitPacket2_i),
    .commitPacket3_i  (commitPacket3_i),
    .recoverStart_i   (recoverStart_i),
    .releaseValid0_o  (releaseValid0_o),
    .releaseValid1_o  (releaseValid1_o),
    .releaseValid2_o  (releaseValid2_o),
    .releaseValid3_o  (releaseValid3_o),
    .releaseTag0_o    (releaseTag0_o),
    .releaseTag1_o    (releaseTag1_o),
    .releaseTag2_o    (releaseTag2_o),
    .releaseTag3_o    (releaseTag3_o),
    .recoverValid_o   (recoverValid),
    .recoverPacket0_o (recoverPacket0),
    .recoverPacket1_o (recoverPacket1),
    .recoverPacket2_o (recoverPacket2),
    .recoverPacket3_o (recoverPacket3),
    .recoverBusy_o    (recoverBusy_o)
  );

  specMapTable specTable (
    .clk              (clk),
    .reset            (reset),
    .renameWe_i       (renameWe_i),
    .renameDest_i     (renameDest_i),
    .renameTag_i      (renameTag_i),
    .lookupDest_i     (lookupDest_i),
    .lookupTag_o      (lookupTag_o),
    .recoverValid_i   (recoverValid),
    .recoverPacket0_i (recoverPacket0),
    .recoverPacket1_i (recoverPacket1),
    .recoverPacket2_i (recoverPacket2),
    .recoverPacket3_i (recoverPacket3)
  );

endmodule

/* verilog/specMapTable.sv */
// Speculative rename map
// One rename write and one lookup per cycle, four recovery writes per cycle

`timescale 1ns/1ps

`include "renameMap_cfg.svh"

module specMapTable (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 renameWe_i,
  input  renamePkg::logIdx_t    renameDest_i,
  input  renamePkg::physTag_t   renameTag_i,
  input  renamePkg::logIdx_t    lookupDest_i,
  output renamePkg::physTag_t   lookupTag_o,
  input  logic                 recoverValid_i,
  input  renamePkg::mapPacket_t recoverPacket0_i,
  input  renamePkg::mapPacket_t recoverPacket1_i,
  input  renamePkg::mapPacket_t recoverPacket2_i,
  input  renamePkg::mapPacket_t recoverPacket3_i
);

  import renamePkg::*;

  physTag_t specArray [`NUM_LOG_REGS];

  // Recovery packet fields
  logIdx_t  recDest0, recDest1, recDest2, recDest3;
  physTag_t recTag0, recTag1, recTag2, recTag3;

  assign recDest0 = recoverPacket0_i[`PHYS_TAG_BITS +: `LOG_IDX_BITS];
  assign recDest1 = recoverPacket1_i[`PHYS_TAG_BITS +: `LOG_IDX_BITS];
  assign recDest2 = recoverPacket2_i[`PHYS_TAG_BITS +: `LOG_IDX_BITS];
  assign recDest3 = recoverPacket3_i[`PHYS_TAG_BITS +: `LOG_IDX_BITS];
  assign recTag0  = recoverPacket0_i[`PHYS_TAG_BITS-1:0];
  assign recTag1  = recoverPacket1_i[`PHYS_TAG_BITS-1:0];
  assign recTag2  = recoverPacket2_i[`PHYS_TAG_BITS-1:0];
  assign recTag3  = recoverPacket3_i[`PHYS_TAG_BITS-1:0];

  // Combinational lookup
  assign lookupTag_o = specArray[lookupDest_i];

  // ##############################
  // Map update
  // ##############################

  // Recovery owns the table for the whole cycle
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < `NUM_LOG_REGS; i++) begin
        specArray[i] <= physTag_t'(i);
      end
    end else if (recoverValid_i) begin
      // Group entries are distinct, so write order does not matter
      specArray[recDest0] <= recTag0;
      specArray[recDest1] <= recTag1;
      specArray[recDest2] <= recTag2;
      specArray[recDest3] <= recTag3;
    end else if (renameWe_i) begin
      specArray[renameDest_i] <= renameTag_i;
    end
  end

endmodule
